/* Makefile */
# Verilator build and run for the outbound assembler testbench

VERILATOR ?= verilator
TOP       ?= tb_asm_out
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TESTBENCH FAILED
PASS_MSG  ?= TESTBENCH PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* asm_out_top.sv */
`timescale 1ns/1ps

// top level of the outbound assembler
// every narrow channel ends in its own two-entry fifo,
// which gives the distributor a ready to peek at
// and gives the outside a registered valid/ready port
module asm_out_top
   import asm_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 rst_i,
   input  logic                                 calibration_done_i,

   // wide input, valid/ready
   input  logic                                 valid_i,
   input  logic [wide_width_lp-1:0]             data_i,
   output logic                                 ready_o,

   input  logic [lane_idx_width_lp-1:0]         in_top_channel_i,
   input  logic [chan_idx_width_lp-1:0]         out_top_channel_i,

   // channel fifo heads, a word leaves on valid_o & ready_i
   output logic [num_chan_lp-1:0]               valid_o,
   output logic [num_chan_lp*word_width_lp-1:0] data_o,
   input  logic [num_chan_lp-1:0]               ready_i
);

   // distributor side of the channel fifos
   logic [num_chan_lp-1:0]               chan_v;
   logic [num_chan_lp*word_width_lp-1:0] chan_data;
   logic [num_chan_lp-1:0]               chan_ready;

   assembler_out asm_out (
      .clk                (clk),
      .rst_i              (rst_i),
      .calibration_done_i (calibration_done_i),
      .valid_i            (valid_i),
      .data_i             (data_i),
      .ready_o            (ready_o),
      .in_top_channel_i   (in_top_channel_i),
      .out_top_channel_i  (out_top_channel_i),
      .valid_o            (chan_v),
      .data_o             (chan_data),
      .ready_i            (chan_ready)
   );

   for (genvar c = 0; c < num_chan_lp; c++)
   begin : g_chan
      // head stays put until the consumer takes it
      two_fifo #(
         .width_p (word_width_lp)
      ) chan_fifo (
         .clk     (clk),
         .rst_i   (rst_i),
         .ready_o (chan_ready[c]),
         .v_i     (chan_v[c]),
         .data_i  (chan_data[c*word_width_lp +: word_width_lp]),
         .v_o     (valid_o[c]),
         .data_o  (data_o[c*word_width_lp +: word_width_lp]),
         .yumi_i  (valid_o[c] & ready_i[c])
      );
   end

endmodule

/* asm_pkg.sv */
package asm_pkg;

   // bits carried by one lane word or one channel word
   localparam int word_width_lp = 8;

   // lanes packed side by side in one wide input word
   localparam int num_lanes_lp = 4;

   // narrow output channels fed by the distributor
   localparam int num_chan_lp = 3;

   // index widths, never narrower than one bit so that
   // a single lane or a single channel still has a port
   localparam int lane_idx_width_lp =
      (num_lanes_lp > 1) ? $clog2(num_lanes_lp) : 1;

   localparam int chan_idx_width_lp =
      (num_chan_lp > 1) ? $clog2(num_chan_lp) : 1;

   // the wide input word
   // lane 0 sits in the least significant slice
   localparam int wide_width_lp = num_lanes_lp * word_width_lp;

endpackage

/* assembler_out.sv */
`timescale 1ns/1ps

// takes one wide word and spreads its lanes round-robin over the narrow channels
// a two-entry fifo per lane lets the wide word be accepted whole
// and then drained a few lanes at a time by the distributor
module assembler_out
   import asm_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 rst_i,
   input  logic                                 calibration_done_i,

   // wide input, valid/ready
   input  logic                                 valid_i,
   input  logic [wide_width_lp-1:0]             data_i,
   output logic                                 ready_o,

   input  logic [lane_idx_width_lp-1:0]         in_top_channel_i,
   input  logic [chan_idx_width_lp-1:0]         out_top_channel_i,

   // narrow channels, ready_i is peeked by the distributor
   output logic [num_chan_lp-1:0]               valid_o,
   output logic [num_chan_lp*word_width_lp-1:0] data_o,
   input  logic [num_chan_lp-1:0]               ready_i
);

   logic [num_lanes_lp-1:0]               lane_ready;
   logic [num_lanes_lp-1:0]               lane_v;
   logic [num_lanes_lp-1:0]               lane_yumi;
   logic [num_lanes_lp*word_width_lp-1:0] lane_data;

   // accept only when every lane fifo has room and the link is calibrated
   // unused lanes never fill, so they never hold this low
   assign ready_o = (&lane_ready) & calibration_done_i;

   for (genvar i = 0; i < num_lanes_lp; i++)
   begin : g_lane
      // lanes above the top one in use stay idle
      logic lane_enq;

      assign lane_enq = valid_i & ready_o & (i <= in_top_channel_i);

      two_fifo #(
         .width_p (word_width_lp)
      ) lane_fifo (
         .clk     (clk),
         .rst_i   (rst_i),
         .ready_o (lane_ready[i]),
         .v_i     (lane_enq),
         .data_i  (data_i[i*word_width_lp +: word_width_lp]),
         .v_o     (lane_v[i]),
         .data_o  (lane_data[i*word_width_lp +: word_width_lp]),
         .yumi_i  (lane_yumi[i])
      );
   end

   // lane fifos share the channels through the round-robin distributor
   rr_fifo_to_fifo rr_dist (
      .clk               (clk),
      .rst_i             (rst_i),
      .in_top_channel_i  (in_top_channel_i),
      .out_top_channel_i (out_top_channel_i),
      .valid_i           (lane_v),
      .data_i            (lane_data),
      .yumi_o            (lane_yumi),
      .valid_o           (valid_o),
      .data_o            (data_o),
      .ready_i           (ready_i)
   );

   // nothing gets in before calibration
   a_ready_needs_cal: assert property (@(posedge clk) disable iff (rst_i)
      !calibration_done_i |-> !ready_o);

endmodule

/* rr_fifo_to_fifo.sv */
`timescale 1ns/1ps

// strict round-robin distributor
// lane fifos on the input side, channel fifos on the output side
// each cycle lanes and channels are walked in step from their pointers,
// so the k-th word of the lane stream always lands on channel k mod channels
module rr_fifo_to_fifo
   import asm_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 rst_i,

   // highest lane and highest channel in use
   // only change while held in reset
   input  logic [lane_idx_width_lp-1:0]         in_top_channel_i,
   input  logic [chan_idx_width_lp-1:0]         out_top_channel_i,

   // lane fifo heads
   input  logic [num_lanes_lp-1:0]              valid_i,
   input  logic [num_lanes_lp*word_width_lp-1:0] data_i,
   output logic [num_lanes_lp-1:0]              yumi_o,

   // channel fifo tails
   // ready_i is peeked before anything is decided
   output logic [num_chan_lp-1:0]               valid_o,
   output logic [num_chan_lp*word_width_lp-1:0] data_o,
   input  logic [num_chan_lp-1:0]               ready_i
);

   // next lane to be drained, next channel to be filled
   logic [lane_idx_width_lp-1:0] lane_ptr_r;
   logic [chan_idx_width_lp-1:0] chan_ptr_r;

   // walking indices, they end up one past the last word moved
   logic [lane_idx_width_lp-1:0] lane_ptr_n;
   logic [chan_idx_width_lp-1:0] chan_ptr_n;

   // set once the walk hits an empty lane or a busy channel
   logic stop;

   always_comb
   begin
      yumi_o     = '0;
      valid_o    = '0;
      data_o     = '0;
      lane_ptr_n = lane_ptr_r;
      chan_ptr_n = chan_ptr_r;
      stop       = 1'b0;

      // at most min(lanes in use, channels in use) words per cycle
      // out_top is below num_chan_lp, so this bound never exceeds either count
      for (int k = 0; k < num_lanes_lp; k++)
      begin
         if (!stop && (k <= in_top_channel_i) && (k <= out_top_channel_i)
             && valid_i[lane_ptr_n] && ready_i[chan_ptr_n])
         begin
            // pair this lane with this channel
            yumi_o[lane_ptr_n]  = 1'b1;
            valid_o[chan_ptr_n] = 1'b1;
            data_o[chan_ptr_n*word_width_lp +: word_width_lp] =
               data_i[lane_ptr_n*word_width_lp +: word_width_lp];

            // step both, wrapping past the top in use
            lane_ptr_n = (lane_ptr_n == in_top_channel_i) ? '0 : lane_ptr_n + 1'b1;
            chan_ptr_n = (chan_ptr_n == out_top_channel_i) ? '0 : chan_ptr_n + 1'b1;
         end
         else
         begin
            // strict order, nothing past a gap may move
            stop = 1'b1;
         end
      end
   end

   // pointers advance by the number of words moved
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         lane_ptr_r <= '0;
         chan_ptr_r <= '0;
      end
      else
      begin
         lane_ptr_r <= lane_ptr_n;
         chan_ptr_r <= chan_ptr_n;
      end
   end

   // only full lane fifos get dequeued
   a_yumi_subset_valid: assert property (@(posedge clk) disable iff (rst_i)
      (yumi_o & ~valid_i) == '0);

   // only ready channel fifos get a word
   a_valid_subset_ready: assert property (@(posedge clk) disable iff (rst_i)
      (valid_o & ~ready_i) == '0);

   // every word taken from a lane is handed to exactly one channel
   a_words_conserved: assert property (@(posedge clk) disable iff (rst_i)
      $countones(yumi_o) == $countones(valid_o));

endmodule

/* sim.f */
asm_pkg.sv
two_fifo.sv
rr_fifo_to_fifo.sv
assembler_out.sv
asm_out_top.sv
tb_asm_out.sv

/* tb_asm_out.sv */
`timescale 1ns/1ps

// testbench for the outbound assembler
// a per-channel reference queue holds every word the DUT must deliver
// concurrent assertions compare the outputs against it each clock
module tb_asm_out
   import asm_pkg::*;
();

   localparam int traffic_limit_lp = 5000;
   localparam int drain_limit_lp   = 2000;

   logic                                 clk = 1'b0;
   logic                                 rst_i;
   logic                                 calibration_done_i;
   logic                                 valid_i;
   logic [wide_width_lp-1:0]             data_i;
   logic                                 ready_o;
   logic [lane_idx_width_lp-1:0]         in_top_channel_i;
   logic [chan_idx_width_lp-1:0]         out_top_channel_i;
   logic [num_chan_lp-1:0]               valid_o;
   logic [num_chan_lp*word_width_lp-1:0] data_o;
   logic [num_chan_lp-1:0]               ready_i;

   // lfsr state, one step per random bit
   logic [31:0] lfsr_state;

   // lane and channel counts of the current phase
   int                     n_lanes;
   int                     n_chan;
   logic [num_chan_lp-1:0] chan_mask;

   // high while outputs must stay idle right after reset
   logic quiet_window;

   // reference queues, one circular buffer per channel
   logic [word_width_lp-1:0] exp_data [num_chan_lp][256];
   int                       wr_idx   [num_chan_lp];
   int                       rd_idx   [num_chan_lp];
   int                       seq_num;
   int                       accepted;
   int                       received;

   // registered copies that the assertions look at
   int                                   exp_cnt  [num_chan_lp];
   logic [word_width_lp-1:0]             exp_head [num_chan_lp];
   logic [num_chan_lp-1:0]               hold_r;
   logic [num_chan_lp*word_width_lp-1:0] last_data_r;
   logic                                 last_rst_r = 1'b0;

   asm_out_top u_dut (
      .clk                (clk),
      .rst_i              (rst_i),
      .calibration_done_i (calibration_done_i),
      .valid_i            (valid_i),
      .data_i             (data_i),
      .ready_o            (ready_o),
      .in_top_channel_i   (in_top_channel_i),
      .out_top_channel_i  (out_top_channel_i),
      .valid_o            (valid_o),
      .data_o             (data_o),
      .ready_i            (ready_i)
   );

   always #4 clk = ~clk;

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function logic take_bit();
      lfsr_state = lfsr_next(lfsr_state);
      return lfsr_state[0];
   endfunction

   function logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r = {r[30:0], take_bit()};
      end
      return r;
   endfunction

   task automatic report_value_error(input string name, input longint expected,
                                     input longint actual);
      $display("[ERROR] %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_failure(input string what);
      $display("%0t ns: %s", $time, what);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   // reference model, updated on every rising edge
   always @(posedge clk)
   begin
      last_rst_r <= rst_i;
      if (rst_i)
      begin
         for (int c = 0; c < num_chan_lp; c++)
         begin
            wr_idx[c]   = 0;
            rd_idx[c]   = 0;
            exp_cnt[c]  <= 0;
            exp_head[c] <= '0;
         end
         seq_num  = 0;
         accepted = 0;
         received = 0;
         hold_r   <= '0;
      end
      else
      begin
         // words leaving the channel fifos
         for (int c = 0; c < num_chan_lp; c++)
         begin
            if (valid_o[c] && ready_i[c])
            begin
               received++;
               if (rd_idx[c] != wr_idx[c])
               begin
                  rd_idx[c]++;
               end
            end
         end
         // used lanes of an accepted wide word, lane 0 first
         if (valid_i && ready_o)
         begin
            accepted++;
            for (int l = 0; l < n_lanes; l++)
            begin
               exp_data[seq_num % n_chan][wr_idx[seq_num % n_chan] % 256] =
                  data_i[l*word_width_lp +: word_width_lp];
               wr_idx[seq_num % n_chan]++;
               seq_num++;
            end
         end
         for (int c = 0; c < num_chan_lp; c++)
         begin
            exp_cnt[c]  <= wr_idx[c] - rd_idx[c];
            exp_head[c] <= exp_data[c][rd_idx[c] % 256];
         end
         hold_r <= valid_o & ~ready_i;
      end
      last_data_r <= data_o;
   end

   for (genvar c = 0; c < num_chan_lp; c++)
   begin : g_chk
      // a word may only leave a channel that still owes one
      a_word_expected: assert property (@(posedge clk) disable iff (rst_i)
         (valid_o[c] && ready_i[c]) |-> (exp_cnt[c] != 0))
         else report_failure($sformatf("channel %0d delivered a word nobody sent to it", c));

      // order and placement
      a_word_value: assert property (@(posedge clk) disable iff (rst_i)
         (valid_o[c] && ready_i[c]) |->
            (data_o[c*word_width_lp +: word_width_lp] == exp_head[c]))
         else report_value_error($sformatf("data_o[%0d]", c), $sampled(exp_head[c]),
                                 $sampled(data_o[c*word_width_lp +: word_width_lp]));

      // a stalled head must not move
      a_hold_valid: assert property (@(posedge clk) disable iff (rst_i)
         hold_r[c] |-> valid_o[c])
         else report_value_error($sformatf("valid_o[%0d]", c), 1, $sampled(valid_o[c]));

      a_hold_data: assert property (@(posedge clk) disable iff (rst_i)
         hold_r[c] |->
            (data_o[c*word_width_lp +: word_width_lp] ==
             last_data_r[c*word_width_lp +: word_width_lp]))
         else report_value_error($sformatf("data_o[%0d]", c),
                                 $sampled(last_data_r[c*word_width_lp +: word_width_lp]),
                                 $sampled(data_o[c*word_width_lp +: word_width_lp]));
   end

   a_cal_gate: assert property (@(posedge clk) disable iff (rst_i)
      !calibration_done_i |-> !ready_o)
      else report_value_error("ready_o", 0, $sampled(ready_o));

   a_ready_after_reset: assert property (@(posedge clk)
      (last_rst_r && !rst_i) |-> (ready_o == calibration_done_i))
      else report_value_error("ready_o", $sampled(calibration_done_i), $sampled(ready_o));

   a_quiet_after_reset: assert property (@(posedge clk)
      quiet_window |-> (valid_o == '0))
      else report_value_error("valid_o", 0, $sampled(valid_o));

   // channels above the top one stay silent
   a_unused_chan: assert property (@(posedge clk) disable iff (rst_i)
      (valid_o & ~chan_mask) == '0)
      else report_value_error("unused valid_o bits", 0, $sampled(valid_o) & ~chan_mask);

   // top channel inputs only change inside reset
   task automatic apply_reset(input int in_top, input int out_top);
      @(posedge clk);
      #1;
      rst_i              = 1'b1;
      calibration_done_i = 1'b0;
      valid_i            = 1'b0;
      in_top_channel_i   = lane_idx_width_lp'(in_top);
      out_top_channel_i  = chan_idx_width_lp'(out_top);
      n_lanes            = in_top + 1;
      n_chan             = out_top + 1;
      for (int c = 0; c < num_chan_lp; c++)
      begin
         chan_mask[c] = (c < n_chan);
      end
      repeat (5) @(posedge clk);
      #1;
      rst_i        = 1'b0;
      quiet_window = 1'b1;
   endtask

   // first no input, then offers that the gate has to refuse
   task automatic calibrate();
      repeat (3) @(posedge clk);
      #1;
      repeat (4)
      begin
         valid_i = take_bit();
         data_i  = take_bits(wide_width_lp);
         @(posedge clk);
         #1;
      end
      valid_i            = 1'b0;
      quiet_window       = 1'b0;
      calibration_done_i = 1'b1;
   endtask

   // heavy back-pressure gives each channel a one in eight chance of ready
   task automatic drive_ready(input bit heavy);
      for (int c = 0; c < num_chan_lp; c++)
      begin
         if (heavy)
         begin
            ready_i[c] = take_bit() & take_bit() & take_bit();
         end
         else
         begin
            ready_i[c] = take_bit();
         end
      end
   endtask

   task automatic run_traffic(input int target, input bit heavy);
      int cycles;
      cycles = 0;
      while (accepted < target)
      begin
         if (cycles == traffic_limit_lp)
         begin
            report_failure($sformatf("only %0d of %0d wide words accepted in %0d cycles",
                                     accepted, target, cycles));
         end
         valid_i = take_bit();
         data_i  = take_bits(wide_width_lp);
         drive_ready(heavy);
         @(posedge clk);
         #1;
         cycles++;
      end
      valid_i = 1'b0;
   endtask

   task automatic drain(input bit heavy);
      int cycles;
      int pending;
      cycles = 0;
      pending = 1;
      while (pending != 0)
      begin
         pending = 0;
         for (int c = 0; c < num_chan_lp; c++)
         begin
            pending += exp_cnt[c];
         end
         if (pending != 0)
         begin
            if (cycles == drain_limit_lp)
            begin
               report_failure($sformatf("%0d words still missing after %0d drain cycles",
                                        pending, cycles));
            end
            drive_ready(heavy);
            @(posedge clk);
            #1;
            cycles++;
         end
      end
      // no loss, every used lane of every accepted word came out
      assert (received == n_lanes * accepted)
         else report_value_error("received word count", n_lanes * accepted, received);
   endtask

   task automatic run_phase(input int in_top, input int out_top, input int target,
                            input bit heavy);
      apply_reset(in_top, out_top);
      calibrate();
      run_traffic(target, heavy);
      drain(heavy);
   endtask

   initial
   begin
      lfsr_state         = 32'h0f15_d8c4;
      rst_i              = 1'b1;
      calibration_done_i = 1'b0;
      valid_i            = 1'b0;
      data_i             = '0;
      ready_i            = '0;
      in_top_channel_i   = lane_idx_width_lp'(num_lanes_lp - 1);
      out_top_channel_i  = chan_idx_width_lp'(num_chan_lp - 1);
      n_lanes            = num_lanes_lp;
      n_chan             = num_chan_lp;
      chan_mask          = '1;
      quiet_window       = 1'b0;

      // all lanes, all channels
      run_phase(3, 2, 200, 1'b0);
      // 3 lanes onto 2 channels
      run_phase(2, 1, 150, 1'b0);
      // single lane fanned out under heavy back-pressure
      run_phase(0, 2, 60, 1'b1);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* two_fifo.sv */
`timescale 1ns/1ps

// two-entry fifo
// input side is ready-then-valid, so v_i is only raised while ready_o is high
// output side is yumi, the consumer takes the head word in the cycle it raises yumi_i
module two_fifo
   import asm_pkg::*;
#(
   parameter int width_p = word_width_lp
)
(
   input  logic               clk,
   input  logic               rst_i,

   // enqueue side
   output logic               ready_o,
   input  logic               v_i,
   input  logic [width_p-1:0] data_i,

   // dequeue side
   output logic               v_o,
   output logic [width_p-1:0] data_o,
   input  logic               yumi_i
);

   // two storage slots, payload only
   logic [width_p-1:0] mem_r [2];

   // one-bit circular pointers
   logic wptr_r;
   logic rptr_r;

   // equal pointers mean either empty or full
   // this flag tells the two apart
   logic full_r;

   logic empty;

   assign empty   = (wptr_r == rptr_r) & ~full_r;
   assign ready_o = ~full_r;
   assign v_o     = ~empty;

   // head word always sits under the read pointer
   assign data_o = mem_r[rptr_r];

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         wptr_r <= 1'b0;
         rptr_r <= 1'b0;
         full_r <= 1'b0;
      end
      else
      begin
         if (v_i)
         begin
            wptr_r <= ~wptr_r;
         end
         if (yumi_i)
         begin
            rptr_r <= ~rptr_r;
         end
         // one word held and a push without a pop fills both slots
         // any pop frees a slot
         if (yumi_i)
         begin
            full_r <= 1'b0;
         end
         else if (v_i && (wptr_r != rptr_r))
         begin
            full_r <= 1'b1;
         end
      end
   end

   // storage write, no reset on payload
   always_ff @(posedge clk)
   begin
      if (v_i)
      begin
         mem_r[wptr_r] <= data_i;
      end
   end

   // producer must respect ready-then-valid
   a_no_enq_when_full: assert property (@(posedge clk) disable iff (rst_i)
      v_i |-> ready_o);

   // consumer may only take a word that is there
   a_no_yumi_when_empty: assert property (@(posedge clk) disable iff (rst_i)
      yumi_i |-> v_o);

endmodule
